/* fes_pkg.sv */
// dram frontend scheduler shared widths, vector types and bus structs
package fes_pkg;

    localparam int FE_WORD_W = 32;
    localparam int BEATS     = 4;
    localparam int BE_WORD_W = FE_WORD_W * BEATS;
    localparam int ADDR_W    = 16;

    typedef logic [FE_WORD_W-1:0]     fe_word_t;
    typedef logic [BE_WORD_W-1:0]     be_word_t;
    // bank, row and column flattened
    typedef logic [ADDR_W-1:0]        addr_t;
    typedef logic [4:0]               req_id_t;
    typedef logic [1:0]               core_num_t;
    typedef logic [$clog2(BEATS)-1:0] beat_idx_t;

    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    // request from the interconnect
    typedef struct packed
    {
        op_e       op;
        addr_t     addr;
        req_id_t   req_id;
        core_num_t core_num;
    } fe_request_t;

    // command toward the backend
    typedef struct packed
    {
        op_e   op;
        addr_t addr;
    } be_command_t;

    typedef struct packed
    {
        addr_t    addr;
        be_word_t data;
    } write_entry_t;

    // response routing of an issued read
    typedef struct packed
    {
        req_id_t   req_id;
        core_num_t core_num;
    } read_tag_t;

endpackage

/* fes_fifo.sv */
// generic synchronous fifo with first-word fall-through output
module fes_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
)
(
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_push,
    input  logic [WIDTH-1:0] i_data,
    input  logic             i_pop,
    output logic [WIDTH-1:0] o_data,
    output logic             o_full,
    output logic             o_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge i_clk)
    begin
        if (i_push)
            mem_q[wr_ptr_q] <= i_data;
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (i_push)
                wr_ptr_q <= next_ptr(wr_ptr_q);
            if (i_pop)
                rd_ptr_q <= next_ptr(rd_ptr_q);
            if (i_push && !i_pop)
                count_q <= count_q + 1'b1;
            else if (i_pop && !i_push)
                count_q <= count_q - 1'b1;
        end
    end

    // head of queue shows without a pop
    assign o_data  = mem_q[rd_ptr_q];
    assign o_full  = (count_q == CNT_W'(DEPTH));
    assign o_empty = (count_q == '0);

    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_push && o_full));

    a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_pop && o_empty));

endmodule

/* fes_intake.sv */
// request intake with write beat gathering, drain control and read parking
module fes_intake import fes_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_req_valid,
    input  fe_request_t  i_req,
    output logic         o_req_ready,
    input  logic         i_wdata_valid,
    input  fe_word_t     i_wdata,
    input  logic         i_wdata_last,
    input  logic         i_rq_full,
    input  logic         i_rq_empty,
    input  logic         i_wq_full,
    input  logic         i_wq_empty,
    input  logic         i_raw_hit,
    input  logic         i_tag_full,
    output logic         o_rd_push,
    output be_command_t  o_rd_cmd,
    output read_tag_t    o_rd_tag,
    output logic         o_wr_push,
    output write_entry_t o_wr_entry,
    output addr_t        o_chk_addr,
    output logic         o_chk_valid
);

    typedef enum logic [1:0] {ACCEPT, GATHER, DRAIN} state_e;

    state_e      state_q;
    addr_t       wr_addr_q;
    be_word_t    gather_q;
    be_word_t    gathered;
    logic        park_valid_q;
    fe_request_t park_req_q;
    fe_request_t rd_src;
    logic        req_hs;
    logic        drain_done;

    ////////////////////
    // acceptance
    ////////////////////
    assign o_req_ready = (state_q == ACCEPT) && !i_rq_full && !i_wq_full && !i_tag_full;
    assign req_hs      = i_req_valid && o_req_ready;

    // every accepted read is checked against queued writes
    assign o_chk_valid = req_hs && (i_req.op == OP_READ);
    assign o_chk_addr  = i_req.addr;

    // parked read may go once both queues are empty
    assign drain_done = (state_q == DRAIN) && i_rq_empty && i_wq_empty && !i_tag_full;

    assign rd_src    = drain_done ? park_req_q : i_req;
    assign o_rd_push = (o_chk_valid && !i_raw_hit) || (drain_done && park_valid_q);
    assign o_rd_cmd  = '{op: OP_READ, addr: rd_src.addr};
    assign o_rd_tag  = '{req_id: rd_src.req_id, core_num: rd_src.core_num};

    ////////////////////
    // write gathering
    ////////////////////
    // first beat ends up in the top quarter
    assign gathered   = {gather_q[BE_WORD_W-FE_WORD_W-1:0], i_wdata};
    assign o_wr_push  = (state_q == GATHER) && i_wdata_valid && i_wdata_last;
    assign o_wr_entry = '{addr: wr_addr_q, data: gathered};

    always_ff @(posedge i_clk)
    begin
        if (req_hs && i_req.op == OP_WRITE)
            wr_addr_q <= i_req.addr;
        if (state_q == GATHER && i_wdata_valid)
            gather_q <= gathered;
        if (o_chk_valid && i_raw_hit)
            park_req_q <= i_req;
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state_q      <= ACCEPT;
            park_valid_q <= 1'b0;
        end
        else
        begin
            case (state_q)
                ACCEPT:
                begin
                    if (req_hs && i_req.op == OP_WRITE)
                        state_q <= GATHER;
                    else if (o_chk_valid && i_raw_hit)
                    begin
                        // hold the hazard read until the writes are out
                        state_q      <= DRAIN;
                        park_valid_q <= 1'b1;
                    end
                    else if (i_wq_full)
                        state_q <= DRAIN;
                end
                GATHER:
                begin
                    if (o_wr_push)
                        state_q <= ACCEPT;
                end
                DRAIN:
                begin
                    if (drain_done)
                    begin
                        state_q      <= ACCEPT;
                        park_valid_q <= 1'b0;
                    end
                end
                default:
                    state_q <= ACCEPT;
            endcase
        end
    end

endmodule

/* fes_write_queue.sv */
// write entry queue with parallel address match for read-after-write hazards
module fes_write_queue import fes_pkg::*;
#(
    parameter int DEPTH = 4
)
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_push,
    input  write_entry_t i_entry,
    input  logic         i_pop,
    output write_entry_t o_entry,
    output logic         o_full,
    output logic         o_empty,
    input  addr_t        i_chk_addr,
    input  logic         i_chk_valid,
    output logic         o_raw_hit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    write_entry_t     slot_q [DEPTH];
    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0] match;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge i_clk)
    begin
        if (i_push)
            slot_q[wr_ptr_q] <= i_entry;
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            valid_q  <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end
        else
        begin
            if (i_push)
            begin
                valid_q[wr_ptr_q] <= 1'b1;
                wr_ptr_q          <= next_ptr(wr_ptr_q);
            end
            if (i_pop)
            begin
                valid_q[rd_ptr_q] <= 1'b0;
                rd_ptr_q          <= next_ptr(rd_ptr_q);
            end
        end
    end

    assign o_entry = slot_q[rd_ptr_q];
    assign o_full  = &valid_q;
    assign o_empty = ~|valid_q;

    ////////////////////
    // hazard compare
    ////////////////////
    always_comb
    begin
        for (int i = 0; i < DEPTH; i++)
            match[i] = valid_q[i] && (slot_q[i].addr == i_chk_addr);
    end

    assign o_raw_hit = i_chk_valid && |match;

endmodule

/* fes_cmd_arbiter.sv */
// read-first command selection and registered command output to the backend
module fes_cmd_arbiter import fes_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  be_command_t  i_rd_cmd,
    input  logic         i_rq_empty,
    output logic         o_rq_pop,
    input  write_entry_t i_wr_entry,
    input  logic         i_wq_empty,
    output logic         o_wq_pop,
    output logic         o_cmd_valid,
    output be_command_t  o_cmd,
    output be_word_t     o_cmd_wdata,
    input  logic         i_cmd_ready
);

    logic load;

    // register free now or freed by the backend this cycle
    assign load     = !o_cmd_valid || i_cmd_ready;
    assign o_rq_pop = load && !i_rq_empty;
    assign o_wq_pop = load && i_rq_empty && !i_wq_empty;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_cmd_valid <= 1'b0;
        else if (load)
            o_cmd_valid <= o_rq_pop || o_wq_pop;
    end

    always_ff @(posedge i_clk)
    begin
        if (o_rq_pop)
            o_cmd <= i_rd_cmd;
        else if (o_wq_pop)
        begin
            o_cmd       <= '{op: OP_WRITE, addr: i_wr_entry.addr};
            o_cmd_wdata <= i_wr_entry.data;
        end
    end

    a_cmd_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_cmd_valid && !i_cmd_ready |=>
            o_cmd_valid && $stable(o_cmd) && $stable(o_cmd_wdata));

endmodule

/* fes_read_return.sv */
// returned read data buffering and beat serializer toward the interconnect
module fes_read_return import fes_pkg::*;
#(
    parameter int RET_DEPTH = 4
)
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_ret_valid,
    input  be_word_t  i_ret_data,
    output logic      o_ret_ready,
    input  logic      i_tag_push,
    input  read_tag_t i_tag,
    output logic      o_tag_full,
    output logic      o_rsp_valid,
    output fe_word_t  o_rsp_data,
    output logic      o_rsp_last,
    output req_id_t   o_rsp_id,
    output core_num_t o_rsp_core,
    input  logic      i_rsp_ready
);

    localparam int CNT_W = $clog2(RET_DEPTH + 1);

    be_word_t   ret_head;
    logic       ret_empty;
    logic       ret_push;
    read_tag_t  tag_head;
    logic       tag_empty;
    logic       word_done;
    beat_idx_t  beat_q;
    logic [CNT_W-1:0] ret_cnt_q;
    logic [CNT_W-1:0] ret_cnt_nxt;

    function automatic fe_word_t quarter(input be_word_t word, input beat_idx_t idx);
        return word[(BEATS - 1 - int'(idx)) * FE_WORD_W +: FE_WORD_W];
    endfunction

    assign ret_push  = i_ret_valid && o_ret_ready;
    assign word_done = o_rsp_valid && i_rsp_ready && o_rsp_last;

    fes_fifo #(.WIDTH(BE_WORD_W), .DEPTH(RET_DEPTH)) u_ret_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (ret_push),
        .i_data  (i_ret_data),
        .i_pop   (word_done),
        .o_data  (ret_head),
        .o_full  (),
        .o_empty (ret_empty)
    );

    // tags also bound the reads in flight
    fes_fifo #(.WIDTH($bits(read_tag_t)), .DEPTH(2 * RET_DEPTH)) u_tag_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (i_tag_push),
        .i_data  (i_tag),
        .i_pop   (word_done),
        .o_data  (tag_head),
        .o_full  (o_tag_full),
        .o_empty (tag_empty)
    );

    ////////////////////
    // backend ready
    ////////////////////
    always_comb
    begin
        ret_cnt_nxt = ret_cnt_q;
        if (ret_push && !word_done)
            ret_cnt_nxt = ret_cnt_q + 1'b1;
        else if (word_done && !ret_push)
            ret_cnt_nxt = ret_cnt_q - 1'b1;
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            ret_cnt_q   <= '0;
            o_ret_ready <= 1'b1;
        end
        else
        begin
            ret_cnt_q   <= ret_cnt_nxt;
            o_ret_ready <= (ret_cnt_nxt != CNT_W'(RET_DEPTH));
        end
    end

    ////////////////////
    // beat serializer
    ////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_rsp_valid <= 1'b0;
            beat_q      <= '0;
        end
        else if (!o_rsp_valid)
            o_rsp_valid <= !ret_empty;
        else if (i_rsp_ready)
        begin
            // counter wraps to zero after the last beat
            beat_q      <= beat_q + 1'b1;
            o_rsp_valid <= !o_rsp_last;
        end
    end

    // head word and tag stay put until the fourth beat is taken
    assign o_rsp_data = quarter(ret_head, beat_q);
    assign o_rsp_last = (beat_q == beat_idx_t'(BEATS - 1));
    assign o_rsp_id   = tag_head.req_id;
    assign o_rsp_core = tag_head.core_num;

    a_tag_present: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_rsp_valid |-> !tag_empty);

endmodule

/* fes_top.sv */
// dram frontend scheduler between the interconnect and the backend controller
module fes_top import fes_pkg::*;
#(
    parameter int RQ_DEPTH  = 4,
    parameter int WQ_DEPTH  = 4,
    parameter int RET_DEPTH = 4
)
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_req_valid,
    input  fe_request_t i_req,
    output logic        o_req_ready,
    input  logic        i_wdata_valid,
    input  fe_word_t    i_wdata,
    input  logic        i_wdata_last,
    output logic        o_cmd_valid,
    output be_command_t o_cmd,
    output be_word_t    o_cmd_wdata,
    input  logic        i_cmd_ready,
    input  logic        i_ret_valid,
    input  be_word_t    i_ret_data,
    output logic        o_ret_ready,
    output logic        o_rsp_valid,
    output fe_word_t    o_rsp_data,
    output logic        o_rsp_last,
    output req_id_t     o_rsp_id,
    output core_num_t   o_rsp_core,
    input  logic        i_rsp_ready
);

    logic         rd_push;
    be_command_t  rd_cmd;
    read_tag_t    rd_tag;
    logic         wr_push;
    write_entry_t wr_entry;
    addr_t        chk_addr;
    logic         chk_valid;
    logic         raw_hit;
    logic         rq_full;
    logic         rq_empty;
    logic         rq_pop;
    be_command_t  rq_head;
    logic         wq_full;
    logic         wq_empty;
    logic         wq_pop;
    write_entry_t wq_head;
    logic         tag_full;

    fes_intake u_intake (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_req_valid   (i_req_valid),
        .i_req         (i_req),
        .o_req_ready   (o_req_ready),
        .i_wdata_valid (i_wdata_valid),
        .i_wdata       (i_wdata),
        .i_wdata_last  (i_wdata_last),
        .i_rq_full     (rq_full),
        .i_rq_empty    (rq_empty),
        .i_wq_full     (wq_full),
        .i_wq_empty    (wq_empty),
        .i_raw_hit     (raw_hit),
        .i_tag_full    (tag_full),
        .o_rd_push     (rd_push),
        .o_rd_cmd      (rd_cmd),
        .o_rd_tag      (rd_tag),
        .o_wr_push     (wr_push),
        .o_wr_entry    (wr_entry),
        .o_chk_addr    (chk_addr),
        .o_chk_valid   (chk_valid)
    );

    // read command queue
    fes_fifo #(.WIDTH($bits(be_command_t)), .DEPTH(RQ_DEPTH)) u_read_queue (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (rd_push),
        .i_data  (rd_cmd),
        .i_pop   (rq_pop),
        .o_data  (rq_head),
        .o_full  (rq_full),
        .o_empty (rq_empty)
    );

    fes_write_queue #(.DEPTH(WQ_DEPTH)) u_write_queue (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_push      (wr_push),
        .i_entry     (wr_entry),
        .i_pop       (wq_pop),
        .o_entry     (wq_head),
        .o_full      (wq_full),
        .o_empty     (wq_empty),
        .i_chk_addr  (chk_addr),
        .i_chk_valid (chk_valid),
        .o_raw_hit   (raw_hit)
    );

    fes_cmd_arbiter u_arbiter (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_rd_cmd    (rq_head),
        .i_rq_empty  (rq_empty),
        .o_rq_pop    (rq_pop),
        .i_wr_entry  (wq_head),
        .i_wq_empty  (wq_empty),
        .o_wq_pop    (wq_pop),
        .o_cmd_valid (o_cmd_valid),
        .o_cmd       (o_cmd),
        .o_cmd_wdata (o_cmd_wdata),
        .i_cmd_ready (i_cmd_ready)
    );

    fes_read_return #(.RET_DEPTH(RET_DEPTH)) u_read_return (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_ret_valid (i_ret_valid),
        .i_ret_data  (i_ret_data),
        .o_ret_ready (o_ret_ready),
        .i_tag_push  (rd_push),
        .i_tag       (rd_tag),
        .o_tag_full  (tag_full),
        .o_rsp_valid (o_rsp_valid),
        .o_rsp_data  (o_rsp_data),
        .o_rsp_last  (o_rsp_last),
        .o_rsp_id    (o_rsp_id),
        .o_rsp_core  (o_rsp_core),
        .i_rsp_ready (i_rsp_ready)
    );

endmodule

/* tb_fes_top.sv */
// testbench for the dram frontend scheduler with backend memory and response model
module tb_fes_top import fes_pkg::*;
();

    localparam int WQ_DEPTH       = 4;
    localparam int N_RAND         = 60;
    localparam int TIMEOUT_CYCLES = 200 * (N_RAND + WQ_DEPTH + 2);

    typedef struct packed
    {
        req_id_t   req_id;
        core_num_t core_num;
        be_word_t  data;
    } exp_rsp_t;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_req_valid;
    fe_request_t i_req;
    logic        o_req_ready;
    logic        i_wdata_valid;
    fe_word_t    i_wdata;
    logic        i_wdata_last;
    logic        o_cmd_valid;
    be_command_t o_cmd;
    be_word_t    o_cmd_wdata;
    logic        i_cmd_ready;
    logic        i_ret_valid;
    be_word_t    i_ret_data;
    logic        o_ret_ready;
    logic        o_rsp_valid;
    fe_word_t    o_rsp_data;
    logic        o_rsp_last;
    req_id_t     o_rsp_id;
    core_num_t   o_rsp_core;
    logic        i_rsp_ready;

    integer      seed = 32'hc9fe4a63;
    be_word_t    be_mem [addr_t];
    be_word_t    ref_mem [addr_t];
    be_word_t    ret_q [$];
    exp_rsp_t    exp_q [$];
    exp_rsp_t    exp_head;
    int          rsp_beat;
    int          be_writes;
    int          writes_sent;
    int          cycles;
    int          wq_taken;
    bit          taken;
    bit          hold_cmd;
    bit          ret_taken;
    bit          rsp_stall;
    bit          cmd_stall;
    fe_word_t    rsp_prev;
    be_command_t cmd_prev;
    be_word_t    wdata_prev;

    fes_top #(.RQ_DEPTH(4), .WQ_DEPTH(WQ_DEPTH), .RET_DEPTH(4)) dut0 (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_req_valid   (i_req_valid),
        .i_req         (i_req),
        .o_req_ready   (o_req_ready),
        .i_wdata_valid (i_wdata_valid),
        .i_wdata       (i_wdata),
        .i_wdata_last  (i_wdata_last),
        .o_cmd_valid   (o_cmd_valid),
        .o_cmd         (o_cmd),
        .o_cmd_wdata   (o_cmd_wdata),
        .i_cmd_ready   (i_cmd_ready),
        .i_ret_valid   (i_ret_valid),
        .i_ret_data    (i_ret_data),
        .o_ret_ready   (o_ret_ready),
        .o_rsp_valid   (o_rsp_valid),
        .o_rsp_data    (o_rsp_data),
        .o_rsp_last    (o_rsp_last),
        .o_rsp_id      (o_rsp_id),
        .o_rsp_core    (o_rsp_core),
        .i_rsp_ready   (i_rsp_ready)
    );

    always #20 i_clk = ~i_clk;

    // eight addresses only, so reads often hit queued writes
    function automatic addr_t addr_of(input int idx);
        return addr_t'(16'h2000 + idx * 16'h0104);
    endfunction

    function automatic be_word_t fill_word(input addr_t a);
        return {8{a}} ^ {4{32'h9e3779b9}};
    endfunction

    task automatic end_failed();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        $display("[FAIL] %0t %s", $time, msg);
        end_failed();
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        end_failed();
    endtask

    ////////////////////
    // request driver
    ////////////////////
    task automatic send_req(input op_e op, input int max_wait, output bit ok);
        fe_request_t req;
        be_word_t    wdata;
        int          waited;
        req.op       = op;
        req.addr     = addr_of($random(seed) & 7);
        req.req_id   = req_id_t'($random(seed));
        req.core_num = core_num_t'($random(seed));
        i_req_valid  = 1'b1;
        i_req        = req;
        ok           = 1'b0;
        waited       = 0;
        while (!ok && waited < max_wait)
        begin
            @(negedge i_clk);
            ok = o_req_ready;
            waited++;
            @(posedge i_clk);
            #1;
        end
        i_req_valid = 1'b0;
        if (ok && op == OP_READ)
            exp_q.push_back('{req_id: req.req_id, core_num: req.core_num, data: ref_mem[req.addr]});
        if (ok && op == OP_WRITE)
        begin
            wdata = {$random(seed), $random(seed), $random(seed), $random(seed)};
            for (int b = 0; b < BEATS; b++)
            begin
                repeat ($random(seed) & 1)
                begin
                    @(posedge i_clk);
                    #1;
                end
                i_wdata_valid = 1'b1;
                i_wdata       = wdata[BE_WORD_W-1-b*FE_WORD_W -: FE_WORD_W];
                i_wdata_last  = (b == BEATS - 1);
                @(posedge i_clk);
                #1;
                i_wdata_valid = 1'b0;
                i_wdata_last  = 1'b0;
            end
            ref_mem[req.addr] = wdata;
            writes_sent++;
        end
    endtask

    initial
    begin
        i_clk = 1'b0;
        i_rst_n = 1'b0;
        i_req_valid = 1'b0;
        i_req = '0;
        i_wdata_valid = 1'b0;
        i_wdata = '0;
        i_wdata_last = 1'b0;
        i_cmd_ready = 1'b0;
        i_ret_valid = 1'b0;
        i_ret_data = '0;
        i_rsp_ready = 1'b0;
        for (int i = 0; i < 8; i++)
        begin
            be_mem[addr_of(i)]  = fill_word(addr_of(i));
            ref_mem[addr_of(i)] = fill_word(addr_of(i));
        end
        repeat (10) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        @(negedge i_clk);
        assert (!o_cmd_valid && !o_rsp_valid && o_req_ready && o_ret_ready)
        else
            value_error("outputs not idle after reset");
        // writes pile up against a stalled backend until intake closes
        hold_cmd = 1'b1;
        @(posedge i_clk);
        #1;
        taken = 1'b1;
        while (taken && wq_taken < WQ_DEPTH + 2)
        begin
            send_req(OP_WRITE, 40, taken);
            if (taken)
                wq_taken++;
        end
        // one write may already sit in the command register
        assert (wq_taken >= WQ_DEPTH && wq_taken <= WQ_DEPTH + 1)
        else
            value_error($sformatf("%0d writes accepted with backend stalled", wq_taken));
        hold_cmd = 1'b0;
        for (int n = 0; n < N_RAND; n++)
        begin
            send_req(op_e'($random(seed) & 1), 400, taken);
            assert (taken)
            else
                abort_run("request was never accepted");
        end
        while (exp_q.size() != 0 || be_writes < writes_sent)
            @(posedge i_clk);
        assert (be_writes == writes_sent)
        else
            value_error($sformatf("%0d writes reached the backend, %0d sent", be_writes, writes_sent));
        for (int i = 0; i < 8; i++)
        begin
            assert (be_mem[addr_of(i)] == ref_mem[addr_of(i)])
            else
                value_error($sformatf("backend word at %h is %h", addr_of(i), be_mem[addr_of(i)]));
        end
        $display("all tests passed");
        $finish;
    end

    ////////////////////
    // backend model
    ////////////////////
    always @(posedge i_clk)
    begin
        #2;
        i_cmd_ready = !hold_cmd && (($random(seed) & 3) != 0);
        i_rsp_ready = ($random(seed) & 3) != 0;
        if (ret_taken)
            i_ret_valid = 1'b0;
        ret_taken = 1'b0;
        if (!i_ret_valid && ret_q.size() != 0 && ($random(seed) & 1))
        begin
            i_ret_valid = 1'b1;
            i_ret_data  = ret_q[0];
        end
    end

    // commands run in issue order, read data captured at issue
    always @(negedge i_clk)
    begin
        if (o_cmd_valid && i_cmd_ready)
        begin
            if (o_cmd.op == OP_WRITE)
            begin
                be_mem[o_cmd.addr] = o_cmd_wdata;
                be_writes++;
            end
            else
                ret_q.push_back(be_mem[o_cmd.addr]);
        end
        if (i_ret_valid && o_ret_ready)
        begin
            void'(ret_q.pop_front());
            ret_taken = 1'b1;
        end
    end

    ////////////////////
    // response and hold checks
    ////////////////////
    always @(negedge i_clk)
    begin
        if (rsp_stall)
            assert (o_rsp_valid && o_rsp_data == rsp_prev)
            else
                value_error("response beat changed while stalled");
        if (cmd_stall)
            assert (o_cmd_valid && o_cmd == cmd_prev && o_cmd_wdata == wdata_prev)
            else
                value_error("backend command changed while stalled");
        rsp_stall  = i_rst_n && o_rsp_valid && !i_rsp_ready;
        cmd_stall  = i_rst_n && o_cmd_valid && !i_cmd_ready;
        rsp_prev   = o_rsp_data;
        cmd_prev   = o_cmd;
        wdata_prev = o_cmd_wdata;
        if (o_rsp_valid && i_rsp_ready)
        begin
            assert (exp_q.size() != 0)
            else
                abort_run("response beat arrived with no read outstanding");
            exp_head = exp_q[0];
            assert (o_rsp_data == exp_head.data[BE_WORD_W-1-rsp_beat*FE_WORD_W -: FE_WORD_W]
                && o_rsp_id == exp_head.req_id && o_rsp_core == exp_head.core_num
                && o_rsp_last == (rsp_beat == BEATS - 1))
            else
                value_error($sformatf("beat %0d data %h id %0d core %0d last %b", rsp_beat,
                    o_rsp_data, o_rsp_id, o_rsp_core, o_rsp_last));
            rsp_beat++;
            if (rsp_beat == BEATS)
            begin
                rsp_beat = 0;
                void'(exp_q.pop_front());
            end
        end
    end

    always @(posedge i_clk)
    begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
            abort_run($sformatf("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

endmodule

/* list.f */
fes_pkg.sv
fes_fifo.sv
fes_intake.sv
fes_write_queue.sv
fes_cmd_arbiter.sv
fes_read_return.sv
fes_top.sv
tb_fes_top.sv
